/* Makefile */
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_top -Mdir $(OBJ) -o tb_top

run: compile
	./$(OBJ)/tb_top +verilator+error+limit+100 | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ) sim.log

/* common/dispatch_pkg.sv */
/*
 * rename/dispatch front end shared definitions
 * sizes, tag types, FU classes, RS packet and RV32I opcodes
 */
`default_nettype none

package dispatch_pkg;

    // ==============================
    // sizes
    // ==============================
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 40;
    localparam int ROB_DEPTH = 16;
    localparam int INIT_FREE = PHYS_REGS - ARCH_REGS;   // tags free after reset

    localparam int FL_PTR_W  = $clog2(INIT_FREE);
    localparam int FL_CNT_W  = $clog2(INIT_FREE + 1);
    localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);   // holds 0..ROB_DEPTH

    typedef logic [4:0]          arch_t;
    typedef logic [5:0]          tag_t;
    typedef logic [3:0]          rob_idx_t;
    typedef logic [FL_PTR_W-1:0] fl_ptr_t;

    typedef enum logic [1:0] {
        FU_ALU    = 2'b00,
        FU_MULT   = 2'b01,
        FU_MEM    = 2'b10,
        FU_BRANCH = 2'b11
    } fu_type_e;

    // packet handed to the reservation stations
    typedef struct packed {
        fu_type_e fu_type;
        rob_idx_t rob_idx;
        tag_t     dest_tag;    // zero when no dest
        logic     has_dest;
        tag_t     src1_tag;
        logic     src1_ready;
        tag_t     src2_tag;
        logic     src2_ready;
    } rs_entry_t;

    // ==============================
    // RV32I opcodes
    // ==============================
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;   // sub / sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;   // M extension

endpackage

`default_nettype wire

/* common/rename_if.sv */
/*
 * rename port between dispatch control and the map table
 */
`timescale 1ns/1ps
`default_nettype none

interface rename_if import dispatch_pkg::*; ();

    // request side
    arch_t src1_arch;
    arch_t src2_arch;
    arch_t dest_arch;
    logic  rename_en;   // write new_tag into dest_arch at the edge
    tag_t  new_tag;

    // combinational lookups of the current table
    tag_t  src1_tag;
    logic  src1_ready;
    tag_t  src2_tag;
    logic  src2_ready;
    tag_t  old_tag;     // previous mapping of dest_arch

    modport disp (
        output src1_arch, src2_arch, dest_arch, rename_en, new_tag,
        input  src1_tag, src1_ready, src2_tag, src2_ready, old_tag
    );

    modport tbl (
        input  src1_arch, src2_arch, dest_arch, rename_en, new_tag,
        output src1_tag, src1_ready, src2_tag, src2_ready, old_tag
    );

endinterface

`default_nettype wire

/* common/rob_alloc_if.sv */
/*
 * ROB allocation port driven by dispatch control
 */
`timescale 1ns/1ps
`default_nettype none

interface rob_alloc_if import dispatch_pkg::*; ();

    logic     alloc_en;    // write entry at tail on the edge
    arch_t    dest_arch;
    tag_t     new_tag;
    tag_t     old_tag;
    logic     has_dest;
    rob_idx_t rob_idx;     // current tail
    logic     full;

    modport disp (output alloc_en, dest_arch, new_tag, old_tag, has_dest, input rob_idx, full);
    modport rob  (input alloc_en, dest_arch, new_tag, old_tag, has_dest, output rob_idx, full);

endinterface

`default_nettype wire

/* rename/free_list.sv */
/*
 * free list of physical tags, circular FIFO
 * pops on dispatch, pushes tags released at commit
 */
`timescale 1ns/1ps
`default_nettype none

module free_list import dispatch_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic alloc_i,          // pop head at the edge
    output tag_t head_tag_o,
    output logic empty_o,
    input  logic release_valid_i,
    input  tag_t release_tag_i
);

    tag_t                slot_q [INIT_FREE];
    fl_ptr_t             head_q;
    fl_ptr_t             tail_q;
    logic [FL_CNT_W-1:0] count_q;
    logic                do_pop;
    logic                do_push;

    function automatic fl_ptr_t fl_next(input fl_ptr_t p);
        fl_next = (p == fl_ptr_t'(INIT_FREE - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty_o    = (count_q == '0);
    assign head_tag_o = slot_q[head_q];

    assign do_pop  = alloc_i && !empty_o;
    // a push into a full ring only fits alongside a pop
    assign do_push = release_valid_i && ((count_q != FL_CNT_W'(INIT_FREE)) || do_pop);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < INIT_FREE; i++)
                slot_q[i] <= tag_t'(ARCH_REGS + i);   // tags above the arch range
            head_q  <= '0;
            tail_q  <= '0;                            // ring starts full
            count_q <= FL_CNT_W'(INIT_FREE);
        end else begin
            if (do_pop)
                head_q <= fl_next(head_q);
            if (do_push) begin
                slot_q[tail_q] <= release_tag_i;
                tail_q         <= fl_next(tail_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;          // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

/* rename/map_table.sv */
/*
 * architectural to physical map table
 * per-tag ready bits, writeback bypass on reads
 */
`timescale 1ns/1ps
`default_nettype none

module map_table import dispatch_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    rename_if.tbl    ren,
    input  logic     writeback_valid_i,
    input  tag_t     writeback_tag_i
);

    tag_t                 map_q [ARCH_REGS];
    logic [PHYS_REGS-1:0] ready_q;           // one bit per physical tag

    // x0 is hardwired, else stored bit or this cycle's writeback
    function automatic logic tag_ready(input arch_t a, input tag_t t);
        tag_ready = (a == '0) || ready_q[t] || (writeback_valid_i && (writeback_tag_i == t));
    endfunction

    // ==============================
    // lookups
    // ==============================
    always_comb begin
        ren.src1_tag   = (ren.src1_arch == '0) ? '0 : map_q[ren.src1_arch];
        ren.src2_tag   = (ren.src2_arch == '0) ? '0 : map_q[ren.src2_arch];
        ren.src1_ready = tag_ready(ren.src1_arch, ren.src1_tag);
        ren.src2_ready = tag_ready(ren.src2_arch, ren.src2_tag);
        ren.old_tag    = map_q[ren.dest_arch];   // goes to ROB as Told
    end

    // ==============================
    // updates
    // ==============================
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++)
                map_q[i] <= tag_t'(i);            // identity mapping
            ready_q <= '1;
        end else begin
            if (writeback_valid_i)
                ready_q[writeback_tag_i] <= 1'b1;
            // later assignment wins, so a rename clear beats the writeback
            if (ren.rename_en && (ren.dest_arch != '0)) begin
                map_q[ren.dest_arch] <= ren.new_tag;
                ready_q[ren.new_tag] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* sources.f */
common/dispatch_pkg.sv
common/rename_if.sv
common/rob_alloc_if.sv
src/decoder.sv
rename/map_table.sv
rename/free_list.sv
src/rob.sv
src/dispatch_stage.sv
src/rename_dispatch_top.sv
tb/dispatch_checker.sv
tb/dispatch_monitor.sv
tb/tb_top.sv

/* src/decoder.sv */
/*
 * RV32I/M decoder for dispatch
 * destination flag, FU class and illegal check
 */
`timescale 1ns/1ps
`default_nettype none

module decoder import dispatch_pkg::*; (
    input  logic [31:0] inst_i,
    input  logic        valid_i,
    output logic        has_dest_o,
    output fu_type_e    fu_type_o,
    output logic        illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        has_dest_o = 1'b0;
        fu_type_o  = FU_ALU;
        illegal_o  = 1'b0;
        if (valid_i) begin
            case (opcode)
                OP_LUI, OP_AUIPC: has_dest_o = 1'b1;
                OP_JAL: begin
                    has_dest_o = 1'b1;           // link register
                    fu_type_o  = FU_BRANCH;
                end
                OP_JALR: begin
                    has_dest_o = 1'b1;
                    fu_type_o  = FU_BRANCH;
                    illegal_o  = (funct3 != 3'b000);
                end
                OP_BRANCH: begin
                    fu_type_o = FU_BRANCH;
                    illegal_o = (funct3 == 3'b010) || (funct3 == 3'b011);
                end
                OP_LOAD: begin
                    has_dest_o = 1'b1;
                    fu_type_o  = FU_MEM;
                    illegal_o  = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                end
                OP_STORE: begin
                    fu_type_o = FU_MEM;
                    illegal_o = (funct3 > 3'b010);   // sb/sh/sw only
                end
                OP_IMM: begin
                    has_dest_o = 1'b1;
                    // shift amounts must have a clean upper field
                    if (funct3 == 3'b001)
                        illegal_o = (funct7 != F7_BASE);
                    else if (funct3 == 3'b101)
                        illegal_o = (funct7 != F7_BASE) && (funct7 != F7_ALT);
                end
                OP_REG: begin
                    has_dest_o = 1'b1;
                    if (funct7 == F7_MULDIV)
                        fu_type_o = FU_MULT;     // mul and div share the unit
                    else if (funct7 == F7_ALT)
                        illegal_o = (funct3 != 3'b000) && (funct3 != 3'b101);
                    else
                        illegal_o = (funct7 != F7_BASE);
                end
                default: illegal_o = 1'b1;
            endcase

            // illegal ops dispatch as plain ALU with no dest
            if (illegal_o) begin
                has_dest_o = 1'b0;
                fu_type_o  = FU_ALU;
            end
        end
    end

endmodule

`default_nettype wire

/* src/dispatch_stage.sv */
/*
 * dispatch control, decode plus resource check and stall
 * drives rename, ROB allocation and free-list pop, builds the RS packet
 */
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage import dispatch_pkg::*; (
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        stall_o,
    output logic        rs_valid_o,
    output rs_entry_t   rs_packet_o,
    output logic        illegal_o,
    rename_if.disp      ren,
    rob_alloc_if.disp   alloc,
    input  logic        free_empty_i,
    input  tag_t        free_tag_i,      // head of the free list
    output logic        free_alloc_o
);

    arch_t    rd;
    arch_t    rs1;
    arch_t    rs2;
    logic     dec_has_dest;
    fu_type_e dec_fu_type;
    logic     accept;
    logic     real_dest;   // writes a register other than x0

    assign rd  = inst_i[11:7];
    assign rs1 = inst_i[19:15];
    assign rs2 = inst_i[24:20];

    decoder u_decoder (
        .inst_i     (inst_i),
        .valid_i    (inst_valid_i),
        .has_dest_o (dec_has_dest),
        .fu_type_o  (dec_fu_type),
        .illegal_o  (illegal_o)
    );

    // ==============================
    // stall and accept
    // ==============================
    assign stall_o   = alloc.full || free_empty_i;   // independent of inst_valid_i
    assign accept    = inst_valid_i && !stall_o;
    assign real_dest = dec_has_dest && (rd != '0);

    assign rs_valid_o   = accept;
    assign free_alloc_o = accept && real_dest;

    // map table request
    assign ren.src1_arch = rs1;
    assign ren.src2_arch = rs2;
    assign ren.dest_arch = rd;
    assign ren.rename_en = accept && real_dest;
    assign ren.new_tag   = free_tag_i;

    // ROB record, no-dest entries carry zeros
    assign alloc.alloc_en  = accept;
    assign alloc.has_dest  = real_dest;
    assign alloc.dest_arch = real_dest ? rd : '0;
    assign alloc.new_tag   = real_dest ? free_tag_i : '0;
    assign alloc.old_tag   = real_dest ? ren.old_tag : '0;

    // ==============================
    // RS packet
    // ==============================
    always_comb begin
        rs_packet_o.fu_type    = dec_fu_type;
        rs_packet_o.rob_idx    = alloc.rob_idx;   // tail of the ROB
        rs_packet_o.has_dest   = real_dest;
        rs_packet_o.dest_tag   = real_dest ? free_tag_i : '0;
        rs_packet_o.src1_tag   = ren.src1_tag;
        rs_packet_o.src1_ready = ren.src1_ready;
        rs_packet_o.src2_tag   = ren.src2_tag;
        rs_packet_o.src2_ready = ren.src2_ready;
    end

endmodule

`default_nettype wire

/* src/rename_dispatch_top.sv */
/*
 * rename and dispatch front end top level
 * dispatch control, map table, free list and ROB
 */
`timescale 1ns/1ps
`default_nettype none

module rename_dispatch_top import dispatch_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic        commit_i,
    input  logic        writeback_valid_i,
    input  tag_t        writeback_tag_i,
    output logic        stall_o,
    output logic        rs_valid_o,
    output rs_entry_t   rs_packet_o,
    output logic        illegal_o,
    output logic        commit_valid_o,
    output arch_t       commit_arch_o,
    output tag_t        commit_tag_o
);

    rename_if    ren_bus ();
    rob_alloc_if alloc_bus ();

    logic free_empty;
    tag_t free_tag;
    logic free_alloc;
    logic release_valid;   // commit of an entry with a dest
    tag_t release_tag;

    dispatch_stage u_dispatch (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .stall_o      (stall_o),
        .rs_valid_o   (rs_valid_o),
        .rs_packet_o  (rs_packet_o),
        .illegal_o    (illegal_o),
        .ren          (ren_bus.disp),
        .alloc        (alloc_bus.disp),
        .free_empty_i (free_empty),
        .free_tag_i   (free_tag),
        .free_alloc_o (free_alloc)
    );

    map_table u_map_table (
        .clock             (clock),
        .reset             (reset),
        .ren               (ren_bus.tbl),
        .writeback_valid_i (writeback_valid_i),
        .writeback_tag_i   (writeback_tag_i)
    );

    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .alloc_i         (free_alloc),
        .head_tag_o      (free_tag),
        .empty_o         (free_empty),
        .release_valid_i (release_valid),
        .release_tag_i   (release_tag)
    );

    rob u_rob (
        .clock           (clock),
        .reset           (reset),
        .alloc           (alloc_bus.rob),
        .commit_i        (commit_i),
        .commit_valid_o  (commit_valid_o),
        .commit_arch_o   (commit_arch_o),
        .commit_tag_o    (commit_tag_o),
        .release_valid_o (release_valid),
        .release_tag_o   (release_tag)
    );

endmodule

`default_nettype wire

/* src/rob.sv */
/*
 * reorder buffer, allocation at tail and commit at head
 * commit hands the previous tag back to the free list
 */
`timescale 1ns/1ps
`default_nettype none

module rob import dispatch_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    rob_alloc_if.rob alloc,
    input  logic     commit_i,
    output logic     commit_valid_o,
    output arch_t    commit_arch_o,
    output tag_t     commit_tag_o,
    output logic     release_valid_o,
    output tag_t     release_tag_o
);

    // entry payload
    arch_t e_arch     [ROB_DEPTH];
    tag_t  e_new_tag  [ROB_DEPTH];
    tag_t  e_old_tag  [ROB_DEPTH];
    logic  e_has_dest [ROB_DEPTH];

    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic [ROB_CNT_W-1:0] count_q;
    logic                 do_alloc;
    logic                 do_commit;

    assign alloc.full    = (count_q == ROB_CNT_W'(ROB_DEPTH));
    assign alloc.rob_idx = tail_q;

    assign do_alloc  = alloc.alloc_en && !alloc.full;
    assign do_commit = commit_i && (count_q != '0);   // empty ROB ignores commit

    // head record, visible during the commit cycle
    assign commit_valid_o  = do_commit;
    assign commit_arch_o   = e_arch[head_q];
    assign commit_tag_o    = e_new_tag[head_q];
    assign release_valid_o = do_commit && e_has_dest[head_q];
    assign release_tag_o   = e_old_tag[head_q];

    always_ff @(posedge clock) begin
        if (do_alloc) begin
            e_arch[tail_q]     <= alloc.dest_arch;
            e_new_tag[tail_q]  <= alloc.new_tag;
            e_old_tag[tail_q]  <= alloc.old_tag;
            e_has_dest[tail_q] <= alloc.has_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_alloc)
                tail_q <= tail_q + 1'b1;   // depth is a power of two
            if (do_commit)
                head_q <= head_q + 1'b1;
            case ({do_alloc, do_commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb/dispatch_checker.sv */
/*
 * protocol assertions on stall, rs_valid and commit_valid
 */
`timescale 1ns/1ps
`default_nettype none

module dispatch_checker (
    input logic clock,
    input logic reset,
    input logic inst_valid_i,
    input logic commit_i,
    input logic stall_i,
    input logic rs_valid_i,
    input logic commit_valid_i
);

    int fail_count = 0;   // failed assertions so far

    // no dispatch while stalled
    a_no_dispatch_in_stall: assert property (@(posedge clock) disable iff (reset)
        !(rs_valid_i && stall_i))
        else begin
            fail_count++;
            $error("rs_valid_o high while stall_o high");
        end

    a_dispatch_needs_valid: assert property (@(posedge clock) disable iff (reset)
        rs_valid_i |-> inst_valid_i)
        else begin
            fail_count++;
            $error("rs_valid_o high without inst_valid_i");
        end

    a_commit_needs_pulse: assert property (@(posedge clock) disable iff (reset)
        commit_valid_i |-> commit_i)
        else begin
            fail_count++;
            $error("commit_valid_o high without commit_i");
        end

    a_quiet_in_reset: assert property (@(posedge clock)
        reset |-> (!rs_valid_i && !commit_valid_i))
        else begin
            fail_count++;
            $error("valid outputs high during reset");
        end

endmodule

bind rename_dispatch_top dispatch_checker u_checker (
    .clock          (clock),
    .reset          (reset),
    .inst_valid_i   (inst_valid_i),
    .commit_i       (commit_i),
    .stall_i        (stall_o),
    .rs_valid_i     (rs_valid_o),
    .commit_valid_i (commit_valid_o)
);

`default_nettype wire

/* tb/dispatch_monitor.sv */
/*
 * output monitor for the front end
 * compares DUT outputs against the current table row
 */
`timescale 1ns/1ps
`default_nettype none

module dispatch_monitor import dispatch_pkg::*; (
    input  logic      clock,
    input  logic      check_en_i,
    // DUT side
    input  logic      stall_i,
    input  logic      rs_valid_i,
    input  rs_entry_t packet_i,
    input  logic      illegal_i,
    input  logic      commit_valid_i,
    input  arch_t     commit_arch_i,
    input  tag_t      commit_tag_i,
    // expected side
    input  logic      exp_stall_i,
    input  logic      exp_rs_valid_i,
    input  rs_entry_t exp_packet_i,
    input  logic      exp_illegal_i,
    input  logic      exp_commit_valid_i,
    input  arch_t     exp_commit_arch_i,
    input  tag_t      exp_commit_tag_i,
    output int        error_count_o
);

    int errors = 0;

    assign error_count_o = errors;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    always @(posedge clock) begin
        #18;   // just before the next edge
        if (check_en_i) begin
            compare("stall_o", stall_i, exp_stall_i);
            compare("rs_valid_o", rs_valid_i, exp_rs_valid_i);
            compare("illegal_o", illegal_i, exp_illegal_i);
            compare("commit_valid_o", commit_valid_i, exp_commit_valid_i);
            // packet only means something on a dispatch
            if (exp_rs_valid_i) begin
                compare("fu_type", packet_i.fu_type, exp_packet_i.fu_type);
                compare("rob_idx", packet_i.rob_idx, exp_packet_i.rob_idx);
                compare("has_dest", packet_i.has_dest, exp_packet_i.has_dest);
                compare("dest_tag", packet_i.dest_tag, exp_packet_i.dest_tag);
                compare("src1_tag", packet_i.src1_tag, exp_packet_i.src1_tag);
                compare("src1_ready", packet_i.src1_ready, exp_packet_i.src1_ready);
                compare("src2_tag", packet_i.src2_tag, exp_packet_i.src2_tag);
                compare("src2_ready", packet_i.src2_ready, exp_packet_i.src2_ready);
            end
            if (exp_commit_valid_i) begin
                compare("commit_arch_o", commit_arch_i, exp_commit_arch_i);
                compare("commit_tag_o", commit_tag_i, exp_commit_tag_i);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
/*
 * testbench for the rename and dispatch front end
 * table of stimulus and expected outputs, applied one row per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top import dispatch_pkg::*; ();

    typedef struct packed {
        logic        inst_valid;
        logic [31:0] inst;
        logic        commit;
        logic        wb_valid;
        tag_t        wb_tag;
        logic        stall;          // expected from here on
        logic        rs_valid;
        logic        illegal;
        rs_entry_t   packet;
        logic        commit_valid;
        arch_t       commit_arch;
        tag_t        commit_tag;
    } row_t;

    logic        clock;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        commit;
    logic        wb_valid;
    tag_t        wb_tag;
    logic        stall;
    logic        rs_valid;
    rs_entry_t   rs_packet;
    logic        illegal;
    logic        commit_valid;
    arch_t       commit_arch;
    tag_t        commit_tag;

    row_t rows [$];
    row_t cur;
    logic check_en;
    logic table_ready;
    int   value_errors;
    int   assert_fails;

    initial clock = 1'b0;
    always #10 clock = ~clock;   // 20 ns period

    rename_dispatch_top DUT (
        .clock             (clock),
        .reset             (reset),
        .inst_valid_i      (inst_valid),
        .inst_i            (inst),
        .commit_i          (commit),
        .writeback_valid_i (wb_valid),
        .writeback_tag_i   (wb_tag),
        .stall_o           (stall),
        .rs_valid_o        (rs_valid),
        .rs_packet_o       (rs_packet),
        .illegal_o         (illegal),
        .commit_valid_o    (commit_valid),
        .commit_arch_o     (commit_arch),
        .commit_tag_o      (commit_tag)
    );

    dispatch_monitor u_monitor (
        .clock              (clock),
        .check_en_i         (check_en),
        .stall_i            (stall),
        .rs_valid_i         (rs_valid),
        .packet_i           (rs_packet),
        .illegal_i          (illegal),
        .commit_valid_i     (commit_valid),
        .commit_arch_i      (commit_arch),
        .commit_tag_i       (commit_tag),
        .exp_stall_i        (cur.stall),
        .exp_rs_valid_i     (cur.rs_valid),
        .exp_packet_i       (cur.packet),
        .exp_illegal_i      (cur.illegal),
        .exp_commit_valid_i (cur.commit_valid),
        .exp_commit_arch_i  (cur.commit_arch),
        .exp_commit_tag_i   (cur.commit_tag),
        .error_count_o      (value_errors)
    );

    // ==============================
    // table helpers
    // ==============================
    function automatic logic [31:0] encode(input logic [6:0] f7, input arch_t rs2,
                                           input arch_t rs1, input logic [2:0] f3,
                                           input arch_t rd, input logic [6:0] op);
        encode = {f7, rs2, rs1, f3, rd, op};
    endfunction

    // dest tag zero means no destination
    function automatic rs_entry_t make_packet(input fu_type_e fu, input rob_idx_t idx,
                                              input tag_t dest, input tag_t s1, input logic r1,
                                              input tag_t s2, input logic r2);
        make_packet = {fu, idx, dest, (dest != '0), s1, r1, s2, r2};
    endfunction

    task automatic push_row(input logic iv, input logic [31:0] ins, input logic cm,
                            input logic wv, input tag_t wt, input logic st, input logic rv,
                            input logic il, input rs_entry_t pk, input logic cv,
                            input arch_t ca, input tag_t ct);
        rows.push_back({iv, ins, cm, wv, wt, st, rv, il, pk, cv, ca, ct});
    endtask

    task automatic dispatch_row(input logic [31:0] ins, input rs_entry_t pk);
        push_row(1'b1, ins, 1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, pk, 1'b0, '0, '0);
    endtask

    task automatic commit_row(input logic st, input logic cv, input arch_t ca, input tag_t ct);
        push_row(1'b0, '0, 1'b1, 1'b0, '0, st, 1'b0, 1'b0, '0, cv, ca, ct);
    endtask

    task automatic build_table();
        logic [31:0] add_x9;
        logic [31:0] store_op;
        arch_t       drain_arch [12];
        tag_t        drain_tag [12];
        add_x9     = encode(F7_BASE, 2, 1, 3'b000, 9, OP_REG);
        store_op   = encode(F7_BASE, 11, 10, 3'b010, 0, OP_STORE);   // sw x11, 0(x10)
        drain_arch = '{2, 3, 4, 5, 0, 0, 0, 6, 7, 0, 8, 9};
        drain_tag  = '{33, 34, 35, 36, 0, 0, 0, 37, 38, 0, 39, 1};

        // identity map, free tags from 32
        dispatch_row(encode(F7_BASE, 3, 2, 0, 1, OP_REG), make_packet(FU_ALU, 0, 32, 2, 1, 3, 1));
        dispatch_row(encode(F7_BASE, 5, 4, 0, 2, OP_REG), make_packet(FU_ALU, 1, 33, 4, 1, 5, 1));
        dispatch_row(encode(F7_BASE, 7, 6, 0, 3, OP_REG), make_packet(FU_ALU, 2, 34, 6, 1, 7, 1));
        // x1, x2 still pending
        dispatch_row(encode(F7_BASE, 2, 1, 0, 4, OP_REG),
                     make_packet(FU_ALU, 3, 35, 32, 0, 33, 0));
        push_row(1'b0, '0, 1'b0, 1'b1, 32, 1'b0, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        // tag 34 written back in the same cycle, bypassed
        push_row(1'b1, encode(F7_BASE, 3, 1, 0, 5, OP_REG), 1'b0, 1'b1, 34, 1'b0, 1'b1, 1'b0,
                 make_packet(FU_ALU, 4, 36, 32, 1, 34, 1), 1'b0, '0, '0);

        // ==============================
        // FU classes, no-dest ops
        // ==============================
        dispatch_row(encode(F7_BASE, 2, 1, 3'b010, 0, OP_STORE),
                     make_packet(FU_MEM, 5, 0, 32, 1, 33, 0));
        dispatch_row(encode(F7_BASE, 4, 3, 0, 0, OP_BRANCH),
                     make_packet(FU_BRANCH, 6, 0, 34, 1, 35, 0));
        dispatch_row(encode(F7_BASE, 2, 1, 0, 0, OP_REG), make_packet(FU_ALU, 7, 0, 32, 1, 33, 0));
        dispatch_row(encode(F7_MULDIV, 3, 1, 0, 6, OP_REG),
                     make_packet(FU_MULT, 8, 37, 32, 1, 34, 1));
        dispatch_row(encode(F7_BASE, 0, 5, 3'b010, 7, OP_LOAD),
                     make_packet(FU_MEM, 9, 38, 36, 0, 0, 1));
        push_row(1'b1, encode(F7_BASE, 0, 0, 0, 8, 7'b1111111), 1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b1,
                 make_packet(FU_ALU, 10, 0, 0, 1, 0, 1), 1'b0, '0, '0);   // unknown opcode

        // eighth writer empties the free list
        dispatch_row(encode(F7_BASE, 0, 0, 0, 8, OP_REG), make_packet(FU_ALU, 11, 39, 0, 1, 0, 1));
        push_row(1'b1, add_x9, 1'b0, 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        push_row(1'b1, add_x9, 1'b1, 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b1, 1, 32);
        dispatch_row(add_x9, make_packet(FU_ALU, 12, 1, 32, 1, 33, 0));   // gets released tag 1

        // drain in allocation order, first row still out of tags
        for (int i = 0; i < 12; i++)
            commit_row(i == 0, 1'b1, drain_arch[i], drain_tag[i]);
        commit_row(1'b0, 1'b0, '0, '0);   // empty ROB

        // ==============================
        // ROB full
        // ==============================
        for (int i = 0; i < 16; i++)
            dispatch_row(store_op, make_packet(FU_MEM, rob_idx_t'(13 + i), 0, 10, 1, 11, 1));
        push_row(1'b1, store_op, 1'b0, 1'b0, '0, 1'b1, 1'b0, 1'b0, '0, 1'b0, '0, '0);
        commit_row(1'b1, 1'b1, '0, '0);
        for (int i = 0; i < 15; i++)
            commit_row(1'b0, 1'b1, '0, '0);
        commit_row(1'b0, 1'b0, '0, '0);
        // free list head is now tag 2
        dispatch_row(encode(F7_BASE, 11, 10, 0, 12, OP_REG),
                     make_packet(FU_ALU, 13, 2, 10, 1, 11, 1));
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        commit      = 1'b0;
        wb_valid    = 1'b0;
        wb_tag      = '0;
        check_en    = 1'b0;
        cur         = '0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clock);
        #2 reset = 1'b0;

        foreach (rows[i]) begin
            @(posedge clock);
            #2;
            cur        = rows[i];
            inst_valid = cur.inst_valid;
            inst       = cur.inst;
            commit     = cur.commit;
            wb_valid   = cur.wb_valid;
            wb_tag     = cur.wb_tag;
            check_en   = 1'b1;
        end

        @(posedge clock);
        #2;
        check_en     = 1'b0;
        inst_valid   = 1'b0;
        commit       = 1'b0;
        wb_valid     = 1'b0;
        assert_fails = DUT.u_checker.fail_count;
        $display("rows %0d, value errors %0d, assertion failures %0d",
                 rows.size(), value_errors, assert_fails);
        if (value_errors == 0 && assert_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // reset, every row, then 20 spare cycles
    initial begin
        wait (table_ready);
        #((10 + rows.size() + 20) * 20);
        $display("run timed out before all table rows were applied");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
